/* verilog/y86_pkg.sv */
//------------------------------------------------------------
// Y86-64 fetch package with opcodes, status codes, the fetch
// record and the feedback and data-port request types.
//------------------------------------------------------------
`default_nettype none

package y86_pkg;

    // Longest Y86-64 instruction in bytes.
    localparam int unsigned INSTR_BYTES = 10;

    typedef enum logic [3:0] {
        I_HALT   = 4'h0,
        I_NOP    = 4'h1,
        I_RRMOVQ = 4'h2, // Also cmovXX, selected by ifun.
        I_IRMOVQ = 4'h3,
        I_RMMOVQ = 4'h4,
        I_MRMOVQ = 4'h5,
        I_OPQ    = 4'h6,
        I_JXX    = 4'h7,
        I_CALL   = 4'h8,
        I_RET    = 4'h9,
        I_PUSHQ  = 4'hA,
        I_POPQ   = 4'hB
    } icode_t;

    typedef enum logic [1:0] {
        AOK = 2'd0,
        HLT = 2'd1,
        ADR = 2'd2,
        INS = 2'd3
    } stat_t;

    typedef struct packed {
        icode_t      icode;
        logic [3:0]  ifun;
        logic [3:0]  rA;
        logic [3:0]  rB;
        logic [63:0] valC;
        logic [63:0] valP;
        logic [63:0] pc;
        stat_t       stat;
    } fetch_rec_t;

    typedef struct packed {
        icode_t      M_icode;
        logic        M_cnd;
        logic [63:0] M_valA;
    } mem_fb_t;

    typedef struct packed {
        icode_t      W_icode;
        logic [63:0] W_valM;
    } wb_fb_t;

    // A read returns the low eight bytes one cycle after its grant.
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [63:0] addr;
        logic [63:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

/* verilog/pc_select.sv */
//------------------------------------------------------------
// Fetch PC selection from prediction and pipeline feedback.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_select (
    input  wire [63:0]            pred_pc,
    input  wire y86_pkg::mem_fb_t mem_fb,
    input  wire y86_pkg::wb_fb_t  wb_fb,
    output logic [63:0]           f_pc
);

    logic mispredict;
    logic ret_done;

    // A not-taken jump in memory means the prediction (taken) was wrong.
    assign mispredict = (mem_fb.M_icode == y86_pkg::I_JXX) && !mem_fb.M_cnd;
    assign ret_done   = (wb_fb.W_icode == y86_pkg::I_RET);

    always_comb
    begin
        if (mispredict)
        begin
            f_pc = mem_fb.M_valA; // Fallthrough address travels in valA.
        end
        else if (ret_done)
        begin
            f_pc = wb_fb.W_valM;  // Return address popped off the stack.
        end
        else
        begin
            f_pc = pred_pc;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_decode.sv */
//------------------------------------------------------------
// Instruction split, align, length and next-PC prediction for
// ten fetched bytes.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
    input  wire [63:0]              pc,
    input  wire [79:0]              bytes,
    output y86_pkg::fetch_rec_t     rec,
    output logic [63:0]             pred_pc
);

    logic [3:0]  raw_icode;
    logic [3:0]  raw_ifun;
    logic [7:0]  reg_byte;
    logic        need_regids;
    logic        need_valc;
    logic        is_branch;
    logic [63:0] valc;
    logic [63:0] valp;

    // Bytes arrive little-endian, byte 0 in the low bits.
    assign raw_icode = bytes[7:4];
    assign raw_ifun  = bytes[3:0];
    assign reg_byte  = bytes[15:8];

    always_comb
    begin
        need_regids = 1'b0;
        need_valc   = 1'b0;
        is_branch   = 1'b0;
        case (y86_pkg::icode_t'(raw_icode))
            y86_pkg::I_RRMOVQ, y86_pkg::I_OPQ,
            y86_pkg::I_PUSHQ, y86_pkg::I_POPQ:
            begin
                need_regids = 1'b1;
            end
            y86_pkg::I_IRMOVQ, y86_pkg::I_RMMOVQ, y86_pkg::I_MRMOVQ:
            begin
                need_regids = 1'b1;
                need_valc   = 1'b1;
            end
            y86_pkg::I_JXX, y86_pkg::I_CALL:
            begin
                need_valc = 1'b1;
                is_branch = 1'b1;
            end
            default:
            begin
                need_regids = 1'b0;
            end
        endcase
    end

    // The constant shifts up one byte when a register byte is present.
    always_comb
    begin
        if (!need_valc)
        begin
            valc = 64'd0;
        end
        else if (need_regids)
        begin
            valc = bytes[79:16];
        end
        else
        begin
            valc = bytes[71:8];
        end
    end

    assign valp = pc + 64'd1 + (need_regids ? 64'd1 : 64'd0) + (need_valc ? 64'd8 : 64'd0);

    // Jumps are predicted taken.
    assign pred_pc = is_branch ? valc : valp;

    always_comb
    begin
        rec.icode = y86_pkg::icode_t'(raw_icode);
        rec.ifun  = raw_ifun;
        rec.rA    = need_regids ? reg_byte[7:4] : 4'hF; // 4'hF is "no register".
        rec.rB    = need_regids ? reg_byte[3:0] : 4'hF;
        rec.valC  = valc;
        rec.valP  = valp;
        rec.pc    = pc;
        if (raw_icode > 4'hB)
        begin
            rec.stat = y86_pkg::INS;
        end
        else if (raw_icode == 4'h0)
        begin
            rec.stat = y86_pkg::HLT;
        end
        else
        begin
            rec.stat = y86_pkg::AOK;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
//------------------------------------------------------------
// Fetch sequencer: predicted PC, instruction reads and the
// registered fetch record.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int MEM_BYTES = 1024
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire                     stall,
    input  wire y86_pkg::mem_fb_t   mem_fb,
    input  wire y86_pkg::wb_fb_t    wb_fb,
    output logic                    ireq,
    output logic [63:0]             iaddr,
    input  wire                     igrant,
    input  wire                     irsp_valid,
    input  wire [79:0]              irsp_data,
    output logic                    f_valid,
    output y86_pkg::fetch_rec_t     f_rec
);

    typedef enum logic [1:0] {
        REQ,
        WAIT,
        HALTED
    } state_t;

    state_t              state;
    logic [63:0]         pred_pc_q;
    logic [63:0]         fetch_pc_q;
    logic [63:0]         f_pc;
    logic                go;
    logic                out_of_range;
    logic                adr_fault;
    y86_pkg::fetch_rec_t dec_rec;
    y86_pkg::fetch_rec_t adr_rec;
    logic [63:0]         dec_pred_pc;

    pc_select pc_select_inst (
        .pred_pc (pred_pc_q),
        .mem_fb  (mem_fb),
        .wb_fb   (wb_fb),
        .f_pc    (f_pc)
    );

    fetch_decode fetch_decode_inst (
        .pc      (fetch_pc_q),
        .bytes   (irsp_data),
        .rec     (dec_rec),
        .pred_pc (dec_pred_pc)
    );

    assign go           = (state == REQ) && run && !stall;
    assign out_of_range = f_pc > 64'(MEM_BYTES - y86_pkg::INSTR_BYTES);
    assign adr_fault    = go && out_of_range;
    assign ireq         = go && !out_of_range;
    assign iaddr        = f_pc;

    always_comb
    begin
        adr_rec      = '0;
        adr_rec.pc   = f_pc;
        adr_rec.valP = f_pc;
        adr_rec.stat = y86_pkg::ADR;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= REQ;
            pred_pc_q <= 64'd0;
            f_valid   <= 1'b0;
        end
        else
        begin
            f_valid <= 1'b0;
            case (state)
                REQ:
                begin
                    if (adr_fault)
                    begin
                        f_valid <= 1'b1;
                        state   <= HALTED;
                    end
                    else if (ireq && igrant)
                    begin
                        state <= WAIT;
                    end
                end
                WAIT:
                begin
                    if (irsp_valid)
                    begin
                        f_valid   <= 1'b1;
                        pred_pc_q <= dec_pred_pc;
                        state     <= (dec_rec.stat == y86_pkg::AOK) ? REQ : HALTED;
                    end
                end
                default:
                begin
                    state <= HALTED; // Only reset leaves this state.
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ireq && igrant)
        begin
            fetch_pc_q <= f_pc; // Feedback only counts in the grant cycle.
        end
        if (adr_fault)
        begin
            f_rec <= adr_rec;
        end
        else if (state == WAIT && irsp_valid)
        begin
            f_rec <= dec_rec;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
//------------------------------------------------------------
// Fixed-priority arbiter for the shared memory port, data side
// first, with response routing.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     ireq,
    input  wire [63:0]              iaddr,
    output logic                    igrant,
    output logic                    irsp_valid,
    output logic [79:0]             irsp_data,
    input  wire y86_pkg::dmem_req_t dmem_req,
    output logic                    drdata_valid,
    output logic [63:0]             drdata,
    output logic                    m_en,
    output logic                    m_we,
    output logic [63:0]             m_addr,
    output logic [63:0]             m_wdata,
    input  wire [79:0]              m_rdata
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA
    } owner_t;

    owner_t owner;
    logic   dgrant;

    assign dgrant = dmem_req.valid;
    assign igrant = ireq && !dmem_req.valid;

    assign m_en    = dgrant || igrant;
    assign m_we    = dgrant && dmem_req.write;
    assign m_addr  = dgrant ? dmem_req.addr : iaddr;
    assign m_wdata = dmem_req.wdata;

    // Remember who owns the read that is in flight. Writes return nothing.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            owner <= OWN_NONE;
        end
        else if (dgrant)
        begin
            owner <= dmem_req.write ? OWN_NONE : OWN_DATA;
        end
        else if (igrant)
        begin
            owner <= OWN_FETCH;
        end
        else
        begin
            owner <= OWN_NONE;
        end
    end

    assign irsp_valid   = (owner == OWN_FETCH);
    assign irsp_data    = m_rdata;
    assign drdata_valid = (owner == OWN_DATA);
    assign drdata       = m_rdata[63:0];

endmodule

`default_nettype wire

/* verilog/unified_mem.sv */
//------------------------------------------------------------
// Byte memory with ten-byte registered reads and 8-byte writes.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module unified_mem #(
    parameter int MEM_BYTES = 1024
) (
    input  wire         clk,
    input  wire         m_en,
    input  wire         m_we,
    input  wire [63:0]  m_addr,
    input  wire [63:0]  m_wdata,
    output logic [79:0] m_rdata
);

    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];

    // The array powers up cleared.
    initial
    begin
        for (int i = 0; i < MEM_BYTES; i++)
        begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk)
    begin
        if (m_en && m_we)
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (m_addr < 64'(MEM_BYTES - i))
                begin
                    mem[AW'(m_addr + 64'(i))] <= m_wdata[8*i +: 8]; // Little-endian.
                end
            end
        end
    end

    // Read data is held while no read is issued.
    always_ff @(posedge clk)
    begin
        if (m_en && !m_we)
        begin
            for (int i = 0; i < y86_pkg::INSTR_BYTES; i++)
            begin
                if (m_addr < 64'(MEM_BYTES - i))
                begin
                    m_rdata[8*i +: 8] <= mem[AW'(m_addr + 64'(i))];
                end
                else
                begin
                    m_rdata[8*i +: 8] <= 8'h00;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
//------------------------------------------------------------
// Fetch stage top: fetch unit and data port share one memory.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int MEM_BYTES = 1024
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire                     stall,
    input  wire y86_pkg::mem_fb_t   mem_fb,
    input  wire y86_pkg::wb_fb_t    wb_fb,
    input  wire y86_pkg::dmem_req_t dmem_req,
    output logic                    drdata_valid,
    output logic [63:0]             drdata,
    output logic                    f_valid,
    output y86_pkg::fetch_rec_t     f_rec
);

    logic        ireq;
    logic [63:0] iaddr;
    logic        igrant;
    logic        irsp_valid;
    logic [79:0] irsp_data;
    logic        m_en;
    logic        m_we;
    logic [63:0] m_addr;
    logic [63:0] m_wdata;
    logic [79:0] m_rdata;

    fetch_unit #(
        .MEM_BYTES (MEM_BYTES)
    ) fetch_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .stall      (stall),
        .mem_fb     (mem_fb),
        .wb_fb      (wb_fb),
        .ireq       (ireq),
        .iaddr      (iaddr),
        .igrant     (igrant),
        .irsp_valid (irsp_valid),
        .irsp_data  (irsp_data),
        .f_valid    (f_valid),
        .f_rec      (f_rec)
    );

    mem_arbiter mem_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ireq         (ireq),
        .iaddr        (iaddr),
        .igrant       (igrant),
        .irsp_valid   (irsp_valid),
        .irsp_data    (irsp_data),
        .dmem_req     (dmem_req),
        .drdata_valid (drdata_valid),
        .drdata       (drdata),
        .m_en         (m_en),
        .m_we         (m_we),
        .m_addr       (m_addr),
        .m_wdata      (m_wdata),
        .m_rdata      (m_rdata)
    );

    unified_mem #(
        .MEM_BYTES (MEM_BYTES)
    ) unified_mem_inst (
        .clk     (clk),
        .m_en    (m_en),
        .m_we    (m_we),
        .m_addr  (m_addr),
        .m_wdata (m_wdata),
        .m_rdata (m_rdata)
    );

endmodule

`default_nettype wire

/* tests/fetch_tb.sv */
//------------------------------------------------------------
// Testbench for the Y86-64 fetch stage with a shared memory.
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int MEM_BYTES = 1024;

    logic                clk;
    logic                rst_n;
    logic                run;
    logic                stall;
    y86_pkg::mem_fb_t    mem_fb;
    y86_pkg::wb_fb_t     wb_fb;
    y86_pkg::dmem_req_t  dmem_req;
    logic                drdata_valid;
    logic [63:0]         drdata;
    logic                f_valid;
    y86_pkg::fetch_rec_t f_rec;

    logic [7:0]          img [MEM_BYTES]; // Image of what memory should hold.
    y86_pkg::fetch_rec_t exp_q [$];
    int                  rec_count;
    int                  cursor;
    int                  seed;

    fetch_top #(
        .MEM_BYTES (MEM_BYTES)
    ) fetch_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .stall        (stall),
        .mem_fb       (mem_fb),
        .wb_fb        (wb_fb),
        .dmem_req     (dmem_req),
        .drdata_valid (drdata_valid),
        .drdata       (drdata),
        .f_valid      (f_valid),
        .f_rec        (f_rec)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
        $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        abort_run();
    endtask

    task automatic raise_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Builds the expected record for the instruction at pc by walking the byte image.
    function automatic y86_pkg::fetch_rec_t ref_fetch(input logic [63:0] pc,
                                                      output logic [63:0] next_pc);
        y86_pkg::fetch_rec_t r;
        logic [3:0]          code;
        bit                  regs;
        bit                  cnst;
        int                  p;
        r       = '0;
        r.pc    = pc;
        next_pc = pc;
        if (pc + y86_pkg::INSTR_BYTES > MEM_BYTES)
        begin
            r.stat = y86_pkg::ADR;
        end
        else
        begin
            p       = int'(pc);
            code    = img[p][7:4];
            regs    = code inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hA, 4'hB};
            cnst    = code inside {4'h3, 4'h4, 4'h5, 4'h7, 4'h8};
            r.icode = y86_pkg::icode_t'(code);
            r.ifun  = img[p][3:0];
            r.rA    = 4'hF;
            r.rB    = 4'hF;
            p++; // Past the opcode byte.
            if (regs)
            begin
                r.rA = img[p][7:4];
                r.rB = img[p][3:0];
                p++;
            end
            if (cnst)
            begin
                for (int i = 0; i < 8; i++)
                begin
                    r.valC[8*i +: 8] = img[p + i];
                end
                p += 8;
            end
            r.valP  = 64'(p); // The next instruction starts where this one ends.
            next_pc = (code == 4'h7 || code == 4'h8) ? r.valC : r.valP;
            if (code > 4'hB)
                r.stat = y86_pkg::INS;
            else if (code == 4'h0)
                r.stat = y86_pkg::HLT;
            else
                r.stat = y86_pkg::AOK;
        end
        return r;
    endfunction

    // Every f_valid is matched against the oldest expected record.
    always @(posedge clk)
    begin
        y86_pkg::fetch_rec_t want;
        if (rst_n && f_valid)
        begin
            assert (exp_q.size() != 0)
            else raise_error("a fetch record arrived when none was expected");
            if (exp_q.size() != 0)
            begin
                want      = exp_q.pop_front();
                rec_count = rec_count + 1;
                assert (f_rec.stat == want.stat)
                else show_mismatch("stat", f_rec.stat, want.stat);
                assert (f_rec.pc == want.pc) else show_mismatch("pc", f_rec.pc, want.pc);
                if (want.stat != y86_pkg::ADR)
                begin
                    assert (f_rec.icode == want.icode)
                    else show_mismatch("icode", f_rec.icode, want.icode);
                    assert (f_rec.ifun == want.ifun)
                    else show_mismatch("ifun", f_rec.ifun, want.ifun);
                    assert (f_rec.rA == want.rA) else show_mismatch("rA", f_rec.rA, want.rA);
                    assert (f_rec.rB == want.rB) else show_mismatch("rB", f_rec.rB, want.rB);
                    assert (f_rec.valC == want.valC)
                    else show_mismatch("valC", f_rec.valC, want.valC);
                    assert (f_rec.valP == want.valP)
                    else show_mismatch("valP", f_rec.valP, want.valP);
                end
            end
        end
    end

    task automatic wait_records(input int target);
        int cycles;
        cycles = 0;
        while (rec_count < target && cycles < 1000)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (rec_count >= target)
        else raise_error("timeout, the expected fetch record did not arrive");
    endtask

    // Any record in this window finds the expected queue empty.
    task automatic quiet_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n          <= 1'b0;
        run            <= 1'b0;
        stall          <= 1'b1;
        mem_fb         <= '0;
        wb_fb          <= '0;
        dmem_req.valid <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic emit(input logic [7:0] op, input logic [7:0] regs, input bit has_regs,
                        input bit has_const, input logic [63:0] valc);
        img[cursor] = op;
        cursor++;
        if (has_regs)
        begin
            img[cursor] = regs;
            cursor++;
        end
        if (has_const)
        begin
            for (int i = 0; i < 8; i++)
            begin
                img[cursor + i] = valc[8*i +: 8];
            end
            cursor += 8;
        end
    endtask

    task automatic data_write(input logic [63:0] addr, input logic [63:0] data);
        for (int i = 0; i < 8; i++)
        begin
            img[int'(addr) + i] = data[8*i +: 8];
        end
        @(posedge clk);
        dmem_req.valid <= 1'b1;
        dmem_req.write <= 1'b1;
        dmem_req.addr  <= addr;
        dmem_req.wdata <= data;
        @(posedge clk);
        dmem_req.valid <= 1'b0;
        @(negedge clk);
        assert (!drdata_valid) else raise_error("a data write returned a read response");
    endtask

    task automatic data_read_check(input logic [63:0] addr);
        logic [63:0] want;
        int          cycles;
        for (int i = 0; i < 8; i++)
        begin
            want[8*i +: 8] = img[int'(addr) + i];
        end
        @(posedge clk);
        dmem_req.valid <= 1'b1;
        dmem_req.write <= 1'b0;
        dmem_req.addr  <= addr;
        @(posedge clk);
        dmem_req.valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!drdata_valid && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (drdata_valid) else raise_error("timeout, data read response did not arrive");
        assert (drdata == want) else show_mismatch("data read", drdata, want);
    endtask

    function automatic y86_pkg::mem_fb_t mem_jump(input logic cnd, input logic [63:0] vala);
        y86_pkg::mem_fb_t fb;
        fb.M_icode = y86_pkg::I_JXX;
        fb.M_cnd   = cnd;
        fb.M_valA  = vala;
        return fb;
    endfunction

    function automatic y86_pkg::wb_fb_t wb_ret(input logic [63:0] valm);
        y86_pkg::wb_fb_t fb;
        fb.W_icode = y86_pkg::I_RET;
        fb.W_valM  = valm;
        return fb;
    endfunction

    // Lifts stall for one cycle so exactly one fetch is granted.
    task automatic step(input y86_pkg::mem_fb_t mfb, input y86_pkg::wb_fb_t wfb,
                        input logic [63:0] pc);
        logic [63:0] nxt;
        exp_q.push_back(ref_fetch(pc, nxt));
        @(posedge clk);
        stall  <= 1'b0;
        mem_fb <= mfb;
        wb_fb  <= wfb;
        @(posedge clk);
        stall  <= 1'b1;
        mem_fb <= '0;
        wb_fb  <= '0;
        wait_records(rec_count + 1);
    endtask

    initial
    begin
        logic [63:0] pc;
        logic [63:0] nxt;
        logic [63:0] word;
        int          target;
        rst_n     = 1'b0;
        run       = 1'b0;
        stall     = 1'b0;
        mem_fb    = '0;
        wb_fb     = '0;
        dmem_req  = '0;
        rec_count = 0;
        seed      = 32'hd23b;
        for (int i = 0; i < MEM_BYTES; i++)
        begin
            img[i] = 8'h00;
        end
        apply_reset();

        cursor = 0;
        emit(8'h10, 8'h00, 0, 0, 64'd0);       // nop at 0
        emit(8'h20, 8'h03, 1, 0, 64'd0);       // rrmovq at 1
        emit(8'h30, 8'hF2, 1, 1, 64'h1234);    // irmovq at 3
        emit(8'h40, 8'h12, 1, 1, 64'h40);      // rmmovq at 13
        emit(8'h50, 8'h31, 1, 1, 64'h80);      // mrmovq at 23
        emit(8'h60, 8'h01, 1, 0, 64'd0);       // opq at 33
        emit(8'h21, 8'h45, 1, 0, 64'd0);       // cmovle at 35
        emit(8'h70, 8'h00, 0, 1, 64'd64);      // jmp at 37
        cursor = 64;
        emit(8'h80, 8'h00, 0, 1, 64'd96);      // call at 64
        cursor = 96;
        emit(8'hA0, 8'h6F, 1, 0, 64'd0);       // pushq at 96
        emit(8'hB0, 8'h7F, 1, 0, 64'd0);       // popq at 98, halt follows at 100
        img[120] = 8'hE0; // Invalid opcode.
        for (int a = 0; a < 128; a += 8)
        begin
            for (int i = 0; i < 8; i++)
            begin
                word[8*i +: 8] = img[a + i];
            end
            data_write(64'(a), word);
        end

        // Fetch runs free along the predicted path while data traffic competes for memory.
        pc = 64'd0;
        do
        begin
            exp_q.push_back(ref_fetch(pc, nxt));
            pc = nxt;
        end
        while (exp_q[$].stat == y86_pkg::AOK && exp_q.size() < 64);
        target = rec_count + exp_q.size();
        @(posedge clk);
        run   <= 1'b1;
        stall <= 1'b0;
        fork
            wait_records(target);
            for (int n = 0; n < 40; n++)
            begin
                pc = 64'd512 + 64'(8 * ($unsigned($random(seed)) % 32));
                if ($random(seed) & 1)
                    data_write(pc, {$random(seed), $random(seed)});
                else
                    data_read_check(pc);
                repeat ($unsigned($random(seed)) % 3) @(posedge clk);
            end
        join
        quiet_cycles(20); // Halted after the halt record.

        // Stall and PC correction are exercised one grant at a time.
        apply_reset();
        @(posedge clk);
        run <= 1'b1;
        quiet_cycles(10);
        step('0, '0, 64'd0);
        quiet_cycles(10);
        step('0, '0, 64'd1);
        step(mem_jump(1'b0, 64'd13), '0, 64'd13);
        step('0, wb_ret(64'd96), 64'd96);
        step(mem_jump(1'b0, 64'd33), wb_ret(64'd98), 64'd33);
        step(mem_jump(1'b1, 64'd98), '0, 64'd35);

        // An invalid opcode stops fetch, and so does an address too near the end.
        apply_reset();
        @(posedge clk);
        run <= 1'b1;
        step(mem_jump(1'b0, 64'd120), '0, 64'd120);
        @(posedge clk);
        stall <= 1'b0;
        quiet_cycles(20);
        apply_reset();
        @(posedge clk);
        run <= 1'b1;
        step('0, wb_ret(64'(MEM_BYTES - 4)), 64'(MEM_BYTES - 4));
        @(posedge clk);
        stall <= 1'b0;
        quiet_cycles(20);

        if (exp_q.size() == 0)
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            raise_error("expected fetch records were left unchecked");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/y86_pkg.sv
verilog/pc_select.sv
verilog/fetch_decode.sv
verilog/fetch_unit.sv
verilog/mem_arbiter.sv
verilog/unified_mem.sv
verilog/fetch_top.sv
tests/fetch_tb.sv
